/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_scoreboard_core
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
common/core_pkg.sv
regfile/register_file.sv
verilog/issue_unit.sv
verilog/exec_pipe.sv
verilog/writeback_stage.sv
verilog/scoreboard_core_top.sv
verif/scoreboard_core_assertions.sv
verif/tb_scoreboard_core.sv

/* common/core_pkg.sv */
package core_pkg;

    localparam int DATA_W     = 32;
    localparam int HALF_W     = DATA_W / 2; // operand split for the multiplier
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 4;          // wraps around
    localparam int MUL_STAGES = 3;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADDI = 3'd4,
        OP_MUL  = 3'd5
    } opcode_e;

    // micro-op as it arrives from outside
    typedef struct packed {
        opcode_e                 op;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;
        logic [REG_ADDR_W-1:0]   rs2;
        logic [DATA_W-1:0]       imm;  // operand b for ADDI
    } uop_t;

    // issued op with its operands already read
    typedef struct packed {
        logic                    valid;
        opcode_e                 op;
        logic [REG_ADDR_W-1:0]   rd;
        logic [TAG_W-1:0]        tag;
        logic [DATA_W-1:0]       a;
        logic [DATA_W-1:0]       b;
    } exec_req_t;

    // finished result, same shape on every path to the register file
    typedef struct packed {
        logic                    valid;
        logic [REG_ADDR_W-1:0]   rd;
        logic [TAG_W-1:0]        tag;
        logic [DATA_W-1:0]       data;
    } result_t;

endpackage

/* regfile/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic [core_pkg::REG_ADDR_W-1:0]   rd_addr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   rd_addr2_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   rd_addr3_i,
    output logic [core_pkg::DATA_W-1:0]       rd_data1_o,
    output logic [core_pkg::DATA_W-1:0]       rd_data2_o,
    output logic                              rd_valid1_o,
    output logic                              rd_valid2_o,
    output logic                              rd_valid3_o,

    input  logic                              tag_set_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   tag_addr_i,
    input  logic [core_pkg::TAG_W-1:0]        tag_i,

    input  core_pkg::result_t                 wr_i
);

    logic [core_pkg::DATA_W-1:0] data_q  [core_pkg::NUM_REGS];
    logic [core_pkg::TAG_W-1:0]  tag_q   [core_pkg::NUM_REGS];
    logic [core_pkg::NUM_REGS-1:0] valid_q;
    logic                        wr_en;

    // result only lands if it belongs to the newest producer of rd
    assign wr_en = wr_i.valid && (wr_i.rd != '0) && (wr_i.tag == tag_q[wr_i.rd]);

    // write-through, so a waiting consumer can issue on the write edge
    function automatic logic [core_pkg::DATA_W-1:0] read_data(
        input logic [core_pkg::REG_ADDR_W-1:0] addr
    );
        if (wr_en && wr_i.rd == addr)
            return wr_i.data;
        return data_q[addr];
    endfunction

    function automatic logic read_valid(input logic [core_pkg::REG_ADDR_W-1:0] addr);
        if (wr_en && wr_i.rd == addr)
            return 1'b1;
        return valid_q[addr];
    endfunction

    assign rd_data1_o  = read_data(rd_addr1_i);
    assign rd_data2_o  = read_data(rd_addr2_i);
    assign rd_valid1_o = read_valid(rd_addr1_i);
    assign rd_valid2_o = read_valid(rd_addr2_i);
    assign rd_valid3_o = read_valid(rd_addr3_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                data_q[i]  <= '0;
                tag_q[i]   <= '0;
                valid_q[i] <= 1'b1;
            end
        end else begin
            if (wr_en) begin
                data_q[wr_i.rd]  <= wr_i.data;
                valid_q[wr_i.rd] <= 1'b1;
            end
            // a new producer on the same edge wins over the write
            if (tag_set_i && tag_addr_i != '0) begin
                tag_q[tag_addr_i]   <= tag_i;
                valid_q[tag_addr_i] <= 1'b0;
            end
        end
    end

endmodule

/* verif/scoreboard_core_assertions.sv */
`timescale 1ns/1ns

module scoreboard_core_assertions (
    input logic clk_i,
    input logic rstn_i,
    input logic stall_i,
    input logic result_valid_i,
    input logic alu_valid_i,
    input logic mul_valid_i
);

    // first cycle out of reset is idle
    assert property (@(posedge clk_i) !rstn_i |=> !stall_i && !result_valid_i)
        else $error("stall or result valid high right after reset");

    // slot reservation keeps the two paths apart
    assert property (@(posedge clk_i) disable iff (!rstn_i) !(alu_valid_i && mul_valid_i))
        else $error("ALU and MUL results valid in the same cycle");

    assert property (@(posedge clk_i) disable iff (!rstn_i) !$isunknown(result_valid_i))
        else $error("result valid is unknown");

endmodule

bind scoreboard_core_top scoreboard_core_assertions i_scoreboard_core_assertions (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .stall_i        (stall_o),
    .result_valid_i (result_o.valid),
    .alu_valid_i    (alu_res.valid),
    .mul_valid_i    (mul_res.valid)
);

/* verif/tb_scoreboard_core.sv */
`timescale 1ns/1ns

module tb_scoreboard_core;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 200;  // cycles per wait loop

    typedef struct packed {
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [core_pkg::TAG_W-1:0]      tag;
        logic [core_pkg::DATA_W-1:0]     data;
    } expect_t;

    logic                            clk;
    logic                            rstn;
    core_pkg::uop_t                  uop;
    logic                            uop_valid;
    logic                            stall;
    core_pkg::result_t               result;

    logic [core_pkg::DATA_W-1:0]     ref_regs [core_pkg::NUM_REGS];
    expect_t                         pending_q [$];  // accepted ops without a result yet
    logic [core_pkg::TAG_W-1:0]      next_tag;       // tags count up from reset and wrap
    logic [core_pkg::REG_ADDR_W-1:0] last_rd;
    int                              error_count;
    int                              result_count;
    int                              accept_count;

    scoreboard_core_top i_scoreboard_core_top (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .uop_i       (uop),
        .uop_valid_i (uop_valid),
        .stall_o     (stall),
        .result_o    (result)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] expected_value(input core_pkg::opcode_e op,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        case (op)
            core_pkg::OP_SUB: return a - b;
            core_pkg::OP_AND: return a & b;
            core_pkg::OP_XOR: return a ^ b;
            core_pkg::OP_MUL: return a * b;  // low 32 bits of the product
            default:          return a + b;
        endcase
    endfunction

    // r0 may have several writes in flight, so the tag picks the entry
    function automatic int find_expected(input logic [core_pkg::REG_ADDR_W-1:0] rd,
                                         input logic [core_pkg::TAG_W-1:0] tag);
        for (int i = 0; i < pending_q.size(); i++) begin
            if (pending_q[i].rd == rd && pending_q[i].tag == tag)
                return i;
        end
        return -1;
    endfunction

    // sequential model, updated in acceptance order
    task automatic record_accept();
        expect_t entry;
        logic [31:0] b;
        b = (uop.op == core_pkg::OP_ADDI) ? uop.imm : ref_regs[uop.rs2];
        entry.rd   = uop.rd;
        entry.tag  = next_tag;
        entry.data = expected_value(uop.op, ref_regs[uop.rs1], b);
        pending_q.push_back(entry);
        if (uop.rd != '0)
            ref_regs[uop.rd] = entry.data;
        next_tag = next_tag + 1'b1;
        accept_count++;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_uop(input core_pkg::opcode_e op,
                             input logic [core_pkg::REG_ADDR_W-1:0] rd,
                             input logic [core_pkg::REG_ADDR_W-1:0] rs1,
                             input logic [core_pkg::REG_ADDR_W-1:0] rs2,
                             input logic [31:0] imm);
        int waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        uop.op    = op;
        uop.rd    = rd;
        uop.rs1   = rs1;
        uop.rs2   = rs2;
        uop.imm   = imm;
        uop_valid = 1'b1;
        while (!accepted && waited < WAIT_LIMIT) begin
            #(CLK_PERIOD/4);  // stall is settled mid cycle
            if (!stall) begin
                accepted = 1'b1;
                record_accept();
            end
            @(negedge clk);
            waited++;
        end
        uop_valid = 1'b0;
        if (!accepted) begin
            error_count++;
            $display("micro-op for r%0d was never accepted, stall stayed high", rd);
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            #(CLK_PERIOD/4);
            if (pending_q.size() == 0)
                done = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            error_count++;
            $display("timed out with %0d results still outstanding", pending_q.size());
            pending_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-20s %s", name, (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    always @(negedge clk) begin : result_monitor
        int idx;
        if (rstn && result.valid === 1'b1) begin
            idx = find_expected(result.rd, result.tag);
            if (idx < 0) begin
                error_count++;
                $display("result for r%0d with tag 0x%0h matches no outstanding micro-op",
                         result.rd, result.tag);
            end else begin
                check_value("result_o.data", result.data, pending_q[idx].data);
                pending_q.delete(idx);
            end
            result_count++;
            last_rd = result.rd;
        end
    end

    task automatic reset_state_test();
        int errs;
        errs = error_count;
        check_value("stall_o", stall, 0);
        check_value("result_o.valid", result.valid, 0);
        issue_uop(core_pkg::OP_ADD, 5'd1, 5'd0, 5'd0, 32'h0);
        wait_for_drain();
        report_test("reset_state", errs);
    endtask

    task automatic independent_ops_test();
        int errs;
        errs = error_count;
        issue_uop(core_pkg::OP_ADDI, 5'd2, 5'd0, 5'd0, 32'h0000_1234);
        issue_uop(core_pkg::OP_ADDI, 5'd3, 5'd0, 5'd0, 32'hf0f0_a5a5);
        wait_for_drain();
        issue_uop(core_pkg::OP_SUB, 5'd4, 5'd2, 5'd3, 32'h0);
        issue_uop(core_pkg::OP_AND, 5'd5, 5'd2, 5'd3, 32'h0);
        issue_uop(core_pkg::OP_XOR, 5'd6, 5'd2, 5'd3, 32'h0);
        wait_for_drain();
        report_test("independent_ops", errs);
    endtask

    task automatic raw_chain_test();
        int errs;
        errs = error_count;
        issue_uop(core_pkg::OP_ADDI, 5'd7, 5'd0, 5'd0, 32'd5);
        issue_uop(core_pkg::OP_ADD, 5'd8, 5'd7, 5'd7, 32'h0);
        issue_uop(core_pkg::OP_SUB, 5'd9, 5'd8, 5'd7, 32'h0);
        issue_uop(core_pkg::OP_XOR, 5'd10, 5'd9, 5'd8, 32'h0);
        issue_uop(core_pkg::OP_ADDI, 5'd11, 5'd10, 5'd0, 32'hffff_fff0);
        wait_for_drain();
        report_test("raw_chain", errs);
    endtask

    task automatic mul_then_alu_test();
        int errs;
        errs = error_count;
        issue_uop(core_pkg::OP_ADDI, 5'd12, 5'd0, 5'd0, 32'h0123_4567);
        issue_uop(core_pkg::OP_ADDI, 5'd13, 5'd0, 5'd0, 32'h89ab_cdef);
        wait_for_drain();
        issue_uop(core_pkg::OP_MUL, 5'd14, 5'd12, 5'd13, 32'h0);
        issue_uop(core_pkg::OP_ADD, 5'd15, 5'd2, 5'd3, 32'h0);
        wait_for_drain();
        check_value("result_o.rd", last_rd, 14);  // multiplier lands after the ALU op
        report_test("mul_then_alu", errs);
    endtask

    task automatic r0_write_test();
        int errs;
        errs = error_count;
        issue_uop(core_pkg::OP_ADDI, 5'd0, 5'd0, 5'd0, 32'h0000_0055);
        wait_for_drain();
        issue_uop(core_pkg::OP_ADD, 5'd16, 5'd0, 5'd0, 32'h0);
        wait_for_drain();
        report_test("r0_write", errs);
    endtask

    task automatic random_ops_test();
        int errs;
        int accepts_before;
        int results_before;
        core_pkg::opcode_e op;
        errs           = error_count;
        accepts_before = accept_count;
        results_before = result_count;
        for (int n = 0; n < 40; n++) begin
            op = core_pkg::opcode_e'(3'($urandom_range(0, 5)));
            issue_uop(op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                      5'($urandom_range(0, 7)), $urandom);
        end
        wait_for_drain();
        check_value("result count", result_count - results_before,
                    accept_count - accepts_before);
        report_test("random_ops", errs);
    endtask

    initial begin
        void'($urandom(32'h5c11563a));
        error_count  = 0;
        result_count = 0;
        accept_count = 0;
        next_tag     = '0;
        last_rd      = '0;
        rstn         = 1'b0;
        uop          = '0;
        uop_valid    = 1'b0;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        reset_state_test();
        independent_ops_test();
        raw_chain_test();
        mul_then_alu_test();
        r0_write_test();
        random_ops_test();

        $display("%0d ops accepted, %0d results, %0d errors",
                 accept_count, result_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog/exec_pipe.sv */
`timescale 1ns/1ns

module exec_pipe (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  core_pkg::exec_req_t   req_i,
    output core_pkg::result_t     alu_res_o,
    output core_pkg::result_t     mul_res_o
);

    localparam int LAST = core_pkg::MUL_STAGES - 1;

    logic                             is_mul;
    logic [core_pkg::DATA_W-1:0]      alu_data;
    logic [core_pkg::DATA_W-1:0]      cross_sum;
    core_pkg::result_t                alu_q;

    logic [core_pkg::MUL_STAGES-1:0]  mul_vld_q;
    logic [core_pkg::REG_ADDR_W-1:0]  mul_rd_q   [core_pkg::MUL_STAGES];
    logic [core_pkg::TAG_W-1:0]       mul_tag_q  [core_pkg::MUL_STAGES];
    logic [core_pkg::DATA_W-1:0]      pp_ll_q;
    logic [core_pkg::HALF_W-1:0]      pp_cross_q;
    logic [core_pkg::DATA_W-1:0]      mul_data_q [1:LAST];

    assign is_mul = req_i.op == core_pkg::OP_MUL;

    always_comb begin
        case (req_i.op)
            core_pkg::OP_SUB: alu_data = req_i.a - req_i.b;
            core_pkg::OP_AND: alu_data = req_i.a & req_i.b;
            core_pkg::OP_XOR: alu_data = req_i.a ^ req_i.b;
            default:          alu_data = req_i.a + req_i.b;  // ADD, ADDI
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            alu_q.valid <= 1'b0;
        end else begin
            alu_q.valid <= req_i.valid && !is_mul;
            alu_q.rd    <= req_i.rd;
            alu_q.tag   <= req_i.tag;
            alu_q.data  <= alu_data;
        end
    end

    // only the low half of the cross terms reaches the low 32 bits
    assign cross_sum = req_i.a[core_pkg::DATA_W-1:core_pkg::HALF_W] * req_i.b[core_pkg::HALF_W-1:0]
                     + req_i.a[core_pkg::HALF_W-1:0] * req_i.b[core_pkg::DATA_W-1:core_pkg::HALF_W];

    always_ff @(posedge clk_i) begin
        if (!rstn_i)
            mul_vld_q <= '0;
        else
            mul_vld_q <= {mul_vld_q[LAST-1:0], req_i.valid && is_mul};
    end

    always_ff @(posedge clk_i) begin
        mul_rd_q[0]  <= req_i.rd;
        mul_tag_q[0] <= req_i.tag;
        pp_ll_q      <= req_i.a[core_pkg::HALF_W-1:0] * req_i.b[core_pkg::HALF_W-1:0];
        pp_cross_q   <= cross_sum[core_pkg::HALF_W-1:0];
        mul_data_q[1] <= pp_ll_q + {pp_cross_q, {core_pkg::HALF_W{1'b0}}};
        for (int s = 1; s < core_pkg::MUL_STAGES; s++) begin
            mul_rd_q[s]  <= mul_rd_q[s-1];
            mul_tag_q[s] <= mul_tag_q[s-1];
        end
        for (int s = 2; s < core_pkg::MUL_STAGES; s++)
            mul_data_q[s] <= mul_data_q[s-1];
    end

    assign alu_res_o = alu_q;

    always_comb begin
        mul_res_o.valid = mul_vld_q[LAST];
        mul_res_o.rd    = mul_rd_q[LAST];
        mul_res_o.tag   = mul_tag_q[LAST];
        mul_res_o.data  = mul_data_q[LAST];
    end

endmodule

/* verilog/issue_unit.sv */
`timescale 1ns/1ns

module issue_unit (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  core_pkg::uop_t                    uop_i,
    input  logic                              uop_valid_i,
    output logic                              stall_o,

    output logic [core_pkg::REG_ADDR_W-1:0]   rd_addr1_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   rd_addr2_o,
    input  logic [core_pkg::DATA_W-1:0]       rd_data1_i,
    input  logic [core_pkg::DATA_W-1:0]       rd_data2_i,
    input  logic                              rd_valid1_i,
    input  logic                              rd_valid2_i,
    input  logic                              dst_valid_i,

    output logic                              tag_set_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   tag_addr_o,
    output logic [core_pkg::TAG_W-1:0]        tag_o,

    output core_pkg::exec_req_t               req_o
);

    logic                        is_mul;
    logic                        uses_rs2;
    logic                        src_ok;
    logic                        slot_ok;
    logic                        accept;
    logic [core_pkg::TAG_W-1:0]  tag_q;
    core_pkg::exec_req_t         req_q;

    // wb_slot_q[n] set: a MUL owns result_o n edges after the next edge
    logic [core_pkg::MUL_STAGES:2] wb_slot_q;

    assign is_mul   = uop_i.op == core_pkg::OP_MUL;
    assign uses_rs2 = uop_i.op != core_pkg::OP_ADDI;

    assign rd_addr1_o = uop_i.rs1;
    assign rd_addr2_o = uop_i.rs2;

    assign src_ok  = rd_valid1_i && (rd_valid2_i || !uses_rs2);
    assign slot_ok = is_mul || !wb_slot_q[2];  // ALU lands at slot +2

    // dst_valid_i low means rd still has a producer in flight (WAW)
    assign stall_o = uop_valid_i && !(src_ok && dst_valid_i && slot_ok);
    assign accept  = uop_valid_i && !stall_o;

    assign tag_set_o  = accept;
    assign tag_addr_o = uop_i.rd;
    assign tag_o      = tag_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tag_q     <= '0;
            wb_slot_q <= '0;
        end else begin
            wb_slot_q <= {accept && is_mul, wb_slot_q[core_pkg::MUL_STAGES:3]};
            if (accept)
                tag_q <= tag_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= accept;
            if (accept) begin
                req_q.op  <= uop_i.op;
                req_q.rd  <= uop_i.rd;
                req_q.tag <= tag_q;
                req_q.a   <= rd_data1_i;
                req_q.b   <= uses_rs2 ? rd_data2_i : uop_i.imm;
            end
        end
    end

    assign req_o = req_q;

endmodule

/* verilog/scoreboard_core_top.sv */
`timescale 1ns/1ns

module scoreboard_core_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  core_pkg::uop_t       uop_i,
    input  logic                 uop_valid_i,
    output logic                 stall_o,
    output core_pkg::result_t    result_o
);

    logic [core_pkg::REG_ADDR_W-1:0] rd_addr1;
    logic [core_pkg::REG_ADDR_W-1:0] rd_addr2;
    logic [core_pkg::DATA_W-1:0]     rd_data1;
    logic [core_pkg::DATA_W-1:0]     rd_data2;
    logic                            rd_valid1;
    logic                            rd_valid2;
    logic                            dst_valid;
    logic                            tag_set;
    logic [core_pkg::REG_ADDR_W-1:0] tag_addr;
    logic [core_pkg::TAG_W-1:0]      tag;
    core_pkg::exec_req_t             exec_req;
    core_pkg::result_t               alu_res;
    core_pkg::result_t               mul_res;
    core_pkg::result_t               wb;

    issue_unit i_issue_unit (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .uop_i       (uop_i),
        .uop_valid_i (uop_valid_i),
        .stall_o     (stall_o),
        .rd_addr1_o  (rd_addr1),
        .rd_addr2_o  (rd_addr2),
        .rd_data1_i  (rd_data1),
        .rd_data2_i  (rd_data2),
        .rd_valid1_i (rd_valid1),
        .rd_valid2_i (rd_valid2),
        .dst_valid_i (dst_valid),
        .tag_set_o   (tag_set),
        .tag_addr_o  (tag_addr),
        .tag_o       (tag),
        .req_o       (exec_req)
    );

    register_file i_register_file (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rd_addr1_i  (rd_addr1),
        .rd_addr2_i  (rd_addr2),
        .rd_addr3_i  (tag_addr),  // rd of the waiting op
        .rd_data1_o  (rd_data1),
        .rd_data2_o  (rd_data2),
        .rd_valid1_o (rd_valid1),
        .rd_valid2_o (rd_valid2),
        .rd_valid3_o (dst_valid),
        .tag_set_i   (tag_set),
        .tag_addr_i  (tag_addr),
        .tag_i       (tag),
        .wr_i        (wb)
    );

    exec_pipe i_exec_pipe (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req_i     (exec_req),
        .alu_res_o (alu_res),
        .mul_res_o (mul_res)
    );

    writeback_stage i_writeback_stage (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .alu_res_i (alu_res),
        .mul_res_i (mul_res),
        .wb_o      (wb)
    );

    assign result_o = wb;

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  core_pkg::result_t   alu_res_i,
    input  core_pkg::result_t   mul_res_i,
    output core_pkg::result_t   wb_o
);

    core_pkg::result_t sel;
    core_pkg::result_t wb_q;

    // slot reservation keeps the two paths apart, so valid stays one-hot
    assign sel = mul_res_i.valid ? mul_res_i : alu_res_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i)
            wb_q.valid <= 1'b0;
        else
            wb_q <= sel;
    end

    assign wb_o = wb_q;  // feeds both the register file and result_o

endmodule
